//--- include/net_config.svh
`ifndef NET_CONFIG_SVH
`define NET_CONFIG_SVH

// One sample per neuron input in a frame
`define NET_INPUTS 15

// Activation, weight and accumulator width
`define NET_WIDTH 32

// Width of one neuron output
`define NET_RESULT_WIDTH 16

// Lowest sum bit kept so the output is sum[28:13]
`define NET_FRAC 13

// Neurons in the layer
`define NET_NODES 4

`endif

//--- hw/netPkg.sv
`include "net_config.svh"

package netPkg;

	// One serial sample
	typedef logic [`NET_WIDTH-1:0] activation_t;

	// One neuron output
	typedef logic [`NET_RESULT_WIDTH-1:0] result_t;

	// Entry 0 holds the newest sample
	typedef activation_t frame_t [`NET_INPUTS];

	// Two's complement weight or bias
	typedef logic signed [`NET_WIDTH-1:0] weight_t;

	// Weights 0 to 14, then the bias at index 15
	typedef weight_t weightRow_t [`NET_INPUTS + 1];

	typedef weightRow_t weightTable_t [`NET_NODES];

	localparam weightTable_t weightTable = '{
		// Node 0
		'{
			1877, 1855, -2403, 4608, -5283, 3113, -5626, -5488,
			101, 5067, 4349, 2311, 5929, 17, 2461,
			1252
		},
		// Node 1
		'{
			-3341, 2207, 4518, -1196, 587, -4702, 3390, 1024,
			-2875, 5531, -640, 2988, -5107, 4163, -733,
			-845
		},
		// Node 2 with mostly negative weights
		'{
			-4471, -5936, 3302, -2219, -1688, 4027, -5395, -812,
			2650, -3754, -4999, 1433, -2086, -5712, 3879,
			2033
		},
		// Node 3
		'{
			5804, -1509, 2741, 3976, -4318, -95, 1260, -3617,
			4892, 688, -2524, -5260, 3105, 2197, -4480,
			-3190
		}
	};

endpackage

//--- hw/countIf.sv
`timescale 1ns/1ps
`include "net_config.svh"

interface countIf;
	localparam int CountWidth = $clog2(`NET_INPUTS);

	logic clear; // Count back to zero
	logic step; // Count up by one
	logic select; // Low for collect limit, high for settle limit
	logic [CountWidth-1:0] count;
	logic last; // Count sits at the selected limit

	modport ctrl
	(
		output clear,
		output step,
		output select,
		input count,
		input last
	);

	modport cnt
	(
		input clear,
		input step,
		input select,
		output count,
		output last
	);
endinterface

//--- hw/sampleBuffer.sv
`timescale 1ns/1ps
`include "net_config.svh"

module sampleBuffer
(
	input logic clk,
	input logic reset,
	input logic shift,
	input netPkg::activation_t sample,
	output netPkg::frame_t frame
);
	netPkg::frame_t entries;

	// Oldest sample of a full frame ends up in the top entry
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			for (int i = 0; i < `NET_INPUTS; i++)
			begin
				entries[i] <= '0;
			end
		end
		else if (shift)
		begin
			for (int i = `NET_INPUTS - 1; i > 0; i--)
			begin
				entries[i] <= entries[i - 1];
			end
			entries[0] <= sample; // Newest sample
		end
	end

	always_comb
	begin
		for (int i = 0; i < `NET_INPUTS; i++)
		begin
			frame[i] = entries[i];
		end
	end

endmodule

//--- hw/sampleCounter.sv
`timescale 1ns/1ps
`include "net_config.svh"

module sampleCounter
(
	input logic clk,
	input logic reset,
	countIf.cnt counter
);
	localparam int CountWidth = $clog2(`NET_INPUTS);

	// Index of the last sample in a frame
	localparam logic [CountWidth-1:0] CollectLimit = CountWidth'(`NET_INPUTS - 1);

	// Settle cycles before the neuron outputs are ready
	localparam logic [CountWidth-1:0] SettleLimit = CountWidth'(2);

	logic [CountWidth-1:0] countReg;
	logic [CountWidth-1:0] limit;

	always_ff @(posedge clk)
	begin
		if (reset || counter.clear)
		begin
			countReg <= '0;
		end
		else if (counter.step)
		begin
			countReg <= countReg + 1'b1;
		end
	end

	assign limit = counter.select ? SettleLimit : CollectLimit;

	assign counter.count = countReg;
	assign counter.last = (countReg == limit);

endmodule

//--- hw/layerControl.sv
`timescale 1ns/1ps

module layerControl
(
	input logic clk,
	input logic reset,
	input logic sampleValid,
	countIf.ctrl counter,
	output logic shift,
	output logic busy,
	output logic resultValid
);
	typedef enum logic [1:0]
	{
		COLLECT,
		SETTLE,
		REPORT
	} state_t;

	state_t state;

	logic accept;

	// Samples are only taken while collecting
	assign accept = (state == COLLECT) && sampleValid;
	assign shift = accept;

	// Counter runs over samples, then over the pipeline cycles
	assign counter.step = accept || (state == SETTLE);
	assign counter.clear = (accept && counter.last) || (state == REPORT);
	assign counter.select = (state != COLLECT);

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= COLLECT;
			busy <= 1'b0;
			resultValid <= 1'b0;
		end
		else
		begin
			case (state)
				COLLECT:
				begin
					if (accept && counter.last) // Fifteenth sample
					begin
						state <= SETTLE;
						busy <= 1'b1;
					end
				end
				SETTLE:
				begin
					if (counter.last)
					begin
						state <= REPORT;
						resultValid <= 1'b1;
					end
				end
				REPORT:
				begin
					state <= COLLECT;
					busy <= 1'b0;
					resultValid <= 1'b0; // Single cycle pulse
				end
				default:
				begin
					state <= COLLECT;
					busy <= 1'b0;
					resultValid <= 1'b0;
				end
			endcase
		end
	end

endmodule

//--- hw/neuronNode.sv
`timescale 1ns/1ps
`include "net_config.svh"

module neuronNode
(
	input logic clk,
	input logic reset,
	input logic enable,
	input netPkg::frame_t frame,
	input netPkg::weightRow_t weights,
	output netPkg::result_t result
);
	localparam int SliceTop = `NET_FRAC + `NET_RESULT_WIDTH - 1;

	netPkg::frame_t frameReg;
	logic [`NET_WIDTH-1:0] sumNext;
	logic [`NET_WIDTH-1:0] sumReg;

	// Wrapping multiply-accumulate where the first sample meets the first weight
	always_comb
	begin
		sumNext = weights[`NET_INPUTS]; // Bias
		for (int i = 0; i < `NET_INPUTS; i++)
		begin
			sumNext = sumNext + frameReg[i] * weights[`NET_INPUTS - 1 - i];
		end
	end

	// Three stages that hold while the layer is idle so results stay put
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			for (int i = 0; i < `NET_INPUTS; i++)
			begin
				frameReg[i] <= '0;
			end
			sumReg <= '0;
			result <= '0;
		end
		else if (enable)
		begin
			for (int i = 0; i < `NET_INPUTS; i++)
			begin
				frameReg[i] <= frame[i];
			end
			sumReg <= sumNext;
			if (sumReg[`NET_WIDTH-1]) // ReLU on the sign bit
			begin
				result <= '0;
			end
			else
			begin
				result <= sumReg[SliceTop:`NET_FRAC];
			end
		end
	end

endmodule

//--- hw/denseLayer.sv
`timescale 1ns/1ps
`include "net_config.svh"

module denseLayer
(
	input logic clk,
	input logic reset,
	input logic enable,
	input netPkg::frame_t frame,
	output netPkg::result_t results [`NET_NODES]
);

	// Same frame to every node with one weight row each
	for (genvar k = 0; k < `NET_NODES; k++)
	begin : gNode
		neuronNode node
		(
			.clk(clk),
			.reset(reset),
			.enable(enable),
			.frame(frame),
			.weights(netPkg::weightTable[k]),
			.result(results[k])
		);
	end

endmodule

//--- hw/netTop.sv
`timescale 1ns/1ps
`include "net_config.svh"

module netTop
(
	input logic clk,
	input logic reset,
	input logic sampleValid,
	input logic [`NET_WIDTH-1:0] sample,
	output logic busy,
	output logic resultValid,
	output logic [`NET_NODES*`NET_RESULT_WIDTH-1:0] results
);
	countIf counterBus();

	logic shift;
	netPkg::frame_t frame;
	netPkg::result_t nodeResults [`NET_NODES];

	sampleBuffer buffer
	(
		.clk(clk),
		.reset(reset),
		.shift(shift),
		.sample(sample),
		.frame(frame)
	);

	sampleCounter counter
	(
		.clk(clk),
		.reset(reset),
		.counter(counterBus.cnt)
	);

	layerControl control
	(
		.clk(clk),
		.reset(reset),
		.sampleValid(sampleValid),
		.counter(counterBus.ctrl),
		.shift(shift),
		.busy(busy),
		.resultValid(resultValid)
	);

	// Pipeline advances only while a frame is in flight
	denseLayer layer
	(
		.clk(clk),
		.reset(reset),
		.enable(busy),
		.frame(frame),
		.results(nodeResults)
	);

	for (genvar k = 0; k < `NET_NODES; k++)
	begin : gPack
		assign results[k*`NET_RESULT_WIDTH +: `NET_RESULT_WIDTH] = nodeResults[k]; // Node 0 low
	end

endmodule

//--- test/tbNetTop.sv
`timescale 1ns/1ps
`include "net_config.svh"

module tbNetTop;
	localparam int ResultBits = `NET_NODES * `NET_RESULT_WIDTH;

	logic clk;
	logic reset;
	logic sampleValid;
	logic [`NET_WIDTH-1:0] sample;
	logic busy;
	logic resultValid;
	logic [ResultBits-1:0] results;

	logic [31:0] rngState = 32'he842dcba;
	logic [`NET_WIDTH-1:0] frameData [`NET_INPUTS];
	logic [`NET_WIDTH-1:0] acceptedQ [$]; // Samples the DUT took in this frame
	logic [ResultBits-1:0] lastResults;
	string testName;

	netTop dut_i
	(
		.clk(clk),
		.reset(reset),
		.sampleValid(sampleValid),
		.sample(sample),
		.busy(busy),
		.resultValid(resultValid),
		.results(results)
	);

	initial
	begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	function automatic logic [31:0] nextRandom();
		logic [31:0] x;
		x = rngState;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		rngState = x;
		return x;
	endfunction

	// Bias plus sample j times weight j with a 32-bit wrap
	function automatic logic [`NET_RESULT_WIDTH-1:0] expectedNode(input int node);
		logic [31:0] sum;
		logic [31:0] weight;
		sum = netPkg::weightTable[node][`NET_INPUTS];
		for (int j = 0; j < `NET_INPUTS; j++)
		begin
			weight = netPkg::weightTable[node][j];
			sum = sum + acceptedQ[j] * weight;
		end
		if (sum[31]) // Negative sum clamps to zero
		begin
			return '0;
		end
		return sum[28:13];
	endfunction

	task automatic valueError(input string what, input logic [ResultBits-1:0] expected,
		input logic [ResultBits-1:0] actual);
		$display("error %s: %s expected %h actual %h", testName, what, expected, actual);
		$display("*** FAILED ***");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic stateError(input string what);
		$display("%s in test %s", what, testName);
		$display("*** FAILED ***");
		$fatal(1, "stopped at the first error");
	endtask

	// Caller has already driven reset high for the coming edge
	task automatic holdReset(input int cycles);
		for (int i = 0; i < cycles; i++)
		begin
			@(posedge clk);
			if (i == cycles - 1)
			begin
				reset <= 1'b0;
			end
			@(negedge clk);
			assert (!busy) else stateError("busy high during reset");
			assert (!resultValid) else stateError("resultValid high during reset");
			assert (results == '0) else valueError("results in reset", '0, results);
		end
		acceptedQ.delete();
		lastResults = '0;
	endtask

	task automatic offerSample(input logic valid, input logic [`NET_WIDTH-1:0] data,
		output logic accepted);
		@(posedge clk);
		sampleValid <= valid;
		sample <= data;
		@(negedge clk);
		accepted = valid && !busy; // Taken at the coming edge
		if (accepted)
		begin
			acceptedQ.push_back(data);
		end
		assert (!resultValid) else stateError("resultValid high outside a report cycle");
		assert (results == lastResults) else valueError("held results", lastResults, results);
	endtask

	task automatic finishFrame(input logic flood);
		int edges;
		logic seen;
		logic [ResultBits-1:0] expected;
		edges = 0;
		seen = 1'b0;
		@(posedge clk); // Edge that takes the fifteenth sample
		sampleValid <= flood;
		sample <= nextRandom();
		while (!seen && edges < 20)
		begin
			@(posedge clk);
			edges++;
			sampleValid <= flood; // Offers while busy must be dropped
			sample <= nextRandom();
			@(negedge clk);
			if (resultValid)
			begin
				seen = 1'b1;
			end
			else
			begin
				assert (busy) else stateError("busy low while a frame is in flight");
			end
		end
		assert (seen) else stateError("timeout waiting for resultValid");
		assert (edges == 3) else valueError("result latency", ResultBits'(3), ResultBits'(edges));
		assert (busy) else stateError("busy low in the report cycle");
		for (int k = 0; k < `NET_NODES; k++)
		begin
			expected[k*`NET_RESULT_WIDTH +: `NET_RESULT_WIDTH] = expectedNode(k);
		end
		assert (results == expected) else valueError("results", expected, results);
		lastResults = expected;
		acceptedQ.delete();
	endtask

	// Random gaps with junk data on idle cycles
	task automatic sendFrame(input logic flood);
		int index;
		int offers;
		logic valid;
		logic accepted;
		index = 0;
		offers = 0;
		while (index < `NET_INPUTS && offers < 200)
		begin
			valid = (nextRandom() & 32'h3) != 32'h0;
			offerSample(valid, valid ? frameData[index] : nextRandom(), accepted);
			if (accepted)
			begin
				index++;
			end
			offers++;
		end
		assert (index == `NET_INPUTS) else stateError("frame was not taken in time");
		finishFrame(flood);
	endtask

	task automatic fillRandom();
		for (int j = 0; j < `NET_INPUTS; j++)
		begin
			frameData[j] = nextRandom();
		end
	endtask

	// Large samples on the negative weights of one node drive its sum below zero
	task automatic fillClamp(input int node);
		logic [31:0] weight;
		for (int j = 0; j < `NET_INPUTS; j++)
		begin
			weight = netPkg::weightTable[node][j];
			if (weight[31])
			begin
				frameData[j] = 32'd20000 + (nextRandom() & 32'h7ff);
			end
			else
			begin
				frameData[j] = nextRandom() & 32'hf;
			end
		end
	endtask

	initial
	begin
		logic accepted;
		reset <= 1'b1;
		sampleValid <= 1'b0;
		sample <= '0;
		testName = "reset state";
		holdReset(16);

		testName = "random frames";
		repeat (200)
		begin
			fillRandom();
			sendFrame(1'b0);
		end

		testName = "relu clamp";
		for (int k = 0; k < `NET_NODES; k++)
		begin
			fillClamp(k);
			sendFrame(1'b0);
			assert (results[k*`NET_RESULT_WIDTH +: `NET_RESULT_WIDTH] == '0)
			else valueError("clamped node", '0, results);
		end

		testName = "back-pressure";
		repeat (20)
		begin
			fillRandom();
			sendFrame(1'b1);
		end

		testName = "reset mid-frame";
		fillRandom();
		for (int i = 0; i < 7; i++)
		begin
			offerSample(1'b1, frameData[i], accepted);
		end
		assert (acceptedQ.size() == 7) else stateError("samples refused before the reset");
		@(posedge clk);
		reset <= 1'b1;
		sampleValid <= 1'b0;
		holdReset(4); // Partial frame is gone
		fillRandom();
		sendFrame(1'b0);

		$display("*** PASSED ***");
		$finish;
	end

endmodule

//--- tb.f
+incdir+include
hw/netPkg.sv
hw/countIf.sv
hw/sampleBuffer.sv
hw/sampleCounter.sv
hw/layerControl.sv
hw/neuronNode.sv
hw/denseLayer.sv
hw/netTop.sv
test/tbNetTop.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the netTop testbench with Verilator

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --timing --assert -f tb.f --top-module tbNetTop -o simNet
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/simNet > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -qF '*** PASSED ***' sim.log; then
	echo "Simulation result: pass"
	exit 0
else
	echo "Simulation result: fail"
	exit 1
fi
